// ==== bench/tb_weight_cache.sv ====
// Grouped records run one driver per row and assume WC_PORTS is 4; golden file holds 64 records
`timescale 1ns/1ps
`include "wcache_config.svh"

module tb_weight_cache;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 cfg_vld;
    logic                                 cfg_bypass;
    logic                                 cfg_rdy;
    logic [`WC_PORTS-1:0]                 req_vld;
    logic [`WC_PORTS-1:0]                 req_last;
    logic [`WC_PORTS-1:0][`WC_ADDR_W-1:0] req_addr;
    logic [`WC_PORTS-1:0]                 req_rdy;
    logic [`WC_PORTS-1:0]                 rsp_vld;
    logic [`WC_PORTS-1:0]                 rsp_last;
    logic [`WC_PORTS-1:0][`WC_DATA_W-1:0] rsp_data;
    logic [`WC_PORTS-1:0]                 rsp_rdy;
    logic                                 wram_add_vld;
    logic                                 wram_add_last;
    logic [`WC_ADDR_W-1:0]                wram_add_addr;
    logic                                 wram_add_rdy;
    logic                                 wram_dat_vld;
    logic                                 wram_dat_last;
    logic [`WC_DATA_W-1:0]                wram_dat_data;
    logic                                 wram_dat_rdy;

    logic [39:0] golden [0:63];
    logic [8:0]  exp_mem [0:3][0:63];
    int          wr_ptr [4];
    int          rd_ptr [4];
    int          n_rec;
    int          err_cnt;
    int          chk_cnt;
    int          ram_reads;
    int          cycles;
    int          ram_cnt;
    logic [31:0] rnd;

    weight_cache_top uut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // A miss row is accepted together with its RAM address
    function automatic logic addr_taken_from_row();
        logic found;
        found = 1'b0;
        for (int p = 0; p < `WC_PORTS; p++) begin
            if (req_vld[p] && req_rdy[p] && req_addr[p] == wram_add_addr
                && req_last[p] == wram_add_last) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ====================
    // RAM model and back-pressure
    // ====================

    always @(posedge clk) begin
        rnd = xorshift(rnd);
        rsp_rdy <= {rnd[7:6] != 0, rnd[5:4] != 0, rnd[3:2] != 0, rnd[1:0] != 0};
        if (rst_n) begin
            if (wram_dat_vld && wram_dat_rdy) begin
                wram_dat_vld <= 1'b0;
                wram_add_rdy <= rnd[10];
            end
            if (wram_add_vld && wram_add_rdy) begin
                ram_reads++;
                chk_cnt++;
                if (!addr_taken_from_row()) begin
                    $display("RAM address %h at %0t came with no matching row request",
                             wram_add_addr, $time);
                    err_cnt++;
                end
                wram_add_rdy  <= 1'b0;
                ram_cnt       <= 1 + int'(rnd[9:8]);
                wram_dat_data <= wram_add_addr[7:0] ^ 8'h5A;
                wram_dat_last <= wram_add_last;
            end else if (ram_cnt != 0) begin
                // Data shows up once the random delay runs out
                if (ram_cnt == 1) begin
                    wram_dat_vld <= 1'b1;
                end
                ram_cnt <= ram_cnt - 1;
            end else if (!wram_dat_vld) begin
                // Idle RAM stalls the address channel now and then
                wram_add_rdy <= rnd[11:10] != 0;
            end
        end
    end

    // Reply checker, in per-row order
    always @(posedge clk) begin
        for (int p = 0; p < `WC_PORTS; p++) begin
            if (rst_n && rsp_vld[p] && rsp_rdy[p]) begin
                chk_cnt++;
                if (rd_ptr[p] == wr_ptr[p]) begin
                    $display("Unexpected reply on row %0d at %0t", p, $time);
                    err_cnt++;
                end else begin
                    if ({rsp_data[p], rsp_last[p]} != exp_mem[p][rd_ptr[p] % 64]) begin
                        $display("ERR t=%0t rsp_data/rsp_last[%0d] got %h exp %h", $time, p,
                                 {rsp_data[p], rsp_last[p]}, exp_mem[p][rd_ptr[p] % 64]);
                        err_cnt++;
                    end
                    rd_ptr[p]++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (n_rec > 0 && cycles > 200 * n_rec) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ====================
    // Stimulus tasks
    // ====================

    task automatic configure(input logic bypass);
        int waited;
        waited = 0;
        @(posedge clk);
        cfg_vld    <= 1'b1;
        cfg_bypass <= bypass;
        do begin
            @(posedge clk);
            waited++;
        end while (!cfg_rdy);
        if (waited > 2) begin
            $display("cfg_rdy took %0d cycles to rise", waited);
            err_cnt++;
        end
        cfg_vld <= 1'b0;
        // One cycle in cfg, then work
        @(posedge clk);
        chk_cnt++;
        if (cfg_rdy) begin
            $display("ERR t=%0t cfg_rdy got 1 exp 0", $time);
            err_cnt++;
        end
        @(posedge clk);
    endtask

    task automatic issue_req(input int p, input logic [39:0] rec);
        @(posedge clk);
        req_vld[p]  <= 1'b1;
        req_addr[p] <= rec[16 +: `WC_ADDR_W];
        req_last[p] <= rec[12];
        do begin
            @(posedge clk);
        end while (!req_rdy[p]);
        exp_mem[p][wr_ptr[p] % 64] = {rec[11:4], rec[12]};
        wr_ptr[p]++;
        req_vld[p] <= 1'b0;
    endtask

    task automatic run_port(input int p, input int first, input int last_idx);
        for (int i = first; i <= last_idx; i++) begin
            if (golden[i][35:32] == p) begin
                issue_req(p, golden[i]);
            end
        end
    endtask

    task automatic drain_all();
        for (int p = 0; p < `WC_PORTS; p++) begin
            while (rd_ptr[p] != wr_ptr[p]) begin
                @(posedge clk);
            end
        end
    endtask

    task automatic check_reads(input int got, input int exp);
        chk_cnt++;
        if (got != exp) begin
            $display("ERR t=%0t ram_reads got %0d exp %0d", $time, got, exp);
            err_cnt++;
        end
    endtask

    initial begin
        int i;
        int j;
        int base;
        int want;
        rnd        = 32'hdc150e16;
        rst_n      = 1'b0;
        cfg_vld    = 1'b0;
        cfg_bypass = 1'b0;
        req_vld    = '0;
        req_last   = '0;
        req_addr   = '0;
        rsp_rdy    = '0;
        wram_add_rdy  = 1'b1;
        wram_dat_vld  = 1'b0;
        wram_dat_last = 1'b0;
        wram_dat_data = '0;
        ram_cnt = 0;
        err_cnt = 0;
        chk_cnt = 0;
        ram_reads = 0;
        cycles = 0;
        n_rec = 0;
        for (int p = 0; p < 4; p++) begin
            wr_ptr[p] = 0;
            rd_ptr[p] = 0;
        end
        for (int k = 0; k < 64; k++) begin
            golden[k] = {4'hF, 36'h0};
        end
        $readmemh("bench/weight_cache_golden.txt", golden);
        while (n_rec < 64 && golden[n_rec][39:36] != 4'hF) begin
            n_rec++;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        chk_cnt++;
        if (!cfg_rdy || rsp_vld != '0 || wram_add_vld) begin
            $display("Outputs after reset are not in their idle state");
            err_cnt++;
        end

        i = 0;
        while (i < n_rec) begin
            case (golden[i][39:36])
                4'h1: configure(1'b1);
                4'h2: configure(1'b0);
                4'h3: begin
                    // All rows at once, reads counted over the group
                    j = i;
                    want = 0;
                    while (j < n_rec && golden[j][39:36] == 4'h3) begin
                        want += golden[j][0];
                        j++;
                    end
                    base = ram_reads;
                    fork
                        run_port(0, i, j - 1);
                        run_port(1, i, j - 1);
                        run_port(2, i, j - 1);
                        run_port(3, i, j - 1);
                    join
                    drain_all();
                    check_reads(ram_reads - base, want);
                    i = j - 1;
                end
                default: begin
                    base = ram_reads;
                    issue_req(golden[i][35:32], golden[i]);
                    drain_all();
                    check_reads(ram_reads - base, golden[i][0]);
                end
            endcase
            i++;
        end
        repeat (4) @(posedge clk);

        $display("checks=%0d errors=%0d records=%0d", chk_cnt, err_cnt, n_rec);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/wcache_assert.sv ====
// Valid holding rules assume the testbench never reconfigures with replies or reads in flight
`timescale 1ns/1ps
`include "wcache_config.svh"

module wcache_assert (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 cfg_rdy,
    input logic [`WC_PORTS-1:0]                 rsp_vld,
    input logic [`WC_PORTS-1:0]                 rsp_rdy,
    input logic [`WC_PORTS-1:0][`WC_DATA_W-1:0] rsp_data,
    input logic                                 wram_add_vld,
    input logic                                 wram_add_rdy,
    input logic [`WC_ADDR_W-1:0]                wram_add_addr,
    input logic                                 wram_dat_vld,
    input logic                                 wram_dat_rdy
);

    logic rd_open;

    // Read in flight from its address transfer until its data transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_open <= 1'b0;
        end else if (wram_add_vld && wram_add_rdy) begin
            rd_open <= 1'b1;
        end else if (wram_dat_vld && wram_dat_rdy) begin
            rd_open <= 1'b0;
        end
    end

    // ====================
    // RAM channel
    // ====================

    a_add_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wram_add_vld && !wram_add_rdy |=> wram_add_vld && $stable(wram_add_addr))
        else $error("RAM address valid dropped before transfer");

    // No second address while a read is outstanding
    a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_open |-> !wram_add_vld)
        else $error("second RAM read issued while one is outstanding");

    a_cfg_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_rdy |-> (rsp_vld == '0))
        else $error("reply valid while configuration is ready");

    // Row replies
    for (genvar p = 0; p < `WC_PORTS; p++) begin : gen_rsp
        a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_vld[p] && !rsp_rdy[p] |=> rsp_vld[p] && $stable(rsp_data[p]))
            else $error("reply valid dropped before transfer");
    end

endmodule

bind weight_cache_top wcache_assert u_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_rdy       (cfg_rdy),
    .rsp_vld       (rsp_vld),
    .rsp_rdy       (rsp_rdy),
    .rsp_data      (rsp_data),
    .wram_add_vld  (wram_add_vld),
    .wram_add_rdy  (wram_add_rdy),
    .wram_add_addr (wram_add_addr),
    .wram_dat_vld  (wram_dat_vld),
    .wram_dat_rdy  (wram_dat_rdy)
);

// ==== bench/weight_cache_golden.txt ====
// Request records, one 10-digit hex word each: kind, port, addr (4), last, data (2), ram read
// kind 0 = single request, 1 = config bypass, 2 = config loop, 3 = grouped request, F = end
1000000000
00001014A1
01001004A1
0201A31F91
2000000000
00010005A1
01010105B1
0201020581
0301030591
00010405E1
01010505F1
02010605C1
03010715D1
02010015A0
03010705D0
0001080521
0101081520
00010005A1
0301020580
02010105B1
0101021581
30020005A1
31020115B1
3202020581
3302031591
30020415E1
31020505F1
32020615C1
33020705D1
3002080521
3102091531
32020A0501
33020B1511
2000000000
02020B1511
03020B0510
F000000000

// ==== source/hit_store.sv ====
// Hits only in loop mode; tags are unique since a returned address already stored is not refilled
`timescale 1ns/1ps
`include "wcache_config.svh"

module hit_store (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 work,
    input  logic                                 clear,
    input  wcache_pkg::wc_mode_t                 mode,
    input  logic [`WC_PORTS-1:0][`WC_ADDR_W-1:0] look_addr,
    output logic [`WC_PORTS-1:0]                 hit,
    output logic [`WC_PORTS-1:0][`WC_DATA_W-1:0] hit_data,
    input  logic                                 fill_vld,
    input  logic [`WC_ADDR_W-1:0]                fill_addr,
    input  logic [`WC_DATA_W-1:0]                fill_data
);
    import wcache_pkg::*;

    logic [`WC_ADDR_W-1:0] tag_mem [`WC_DEPTH];
    logic [`WC_DATA_W-1:0] dat_mem [`WC_DEPTH];
    logic [`WC_DEPTH-1:0]  ent_vld;
    logic [`WC_IDX_W-1:0]  fill_ptr;

    logic [`WC_ADDR_W-1:0] last_addr;
    logic [`WC_DATA_W-1:0] last_data;
    logic                  last_vld;

    logic                  loop_on;
    logic                  fill_present;
    logic                  fill_wr;

    assign loop_on = work && (mode == WC_LOOP);

    // ====================
    // Per-port lookup
    // ====================

    always_comb begin
        logic found;
        for (int p = 0; p < `WC_PORTS; p++) begin
            found       = 1'b0;
            hit_data[p] = last_data;
            for (int e = 0; e < `WC_DEPTH; e++) begin
                if (!found && ent_vld[e] && (tag_mem[e] == look_addr[p])) begin
                    found       = 1'b1;
                    hit_data[p] = dat_mem[e];
                end
            end
            // Last access answers too, e.g. right after an eviction
            if (last_vld && (last_addr == look_addr[p])) begin
                found = 1'b1;
            end
            hit[p] = loop_on && found;
        end
    end

    // ====================
    // Fill on RAM return
    // ====================

    always_comb begin
        fill_present = 1'b0;
        for (int e = 0; e < `WC_DEPTH; e++) begin
            if (ent_vld[e] && (tag_mem[e] == fill_addr)) begin
                fill_present = 1'b1;
            end
        end
    end

    assign fill_wr = fill_vld && loop_on && !fill_present;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_vld  <= '0;
            fill_ptr <= '0;
            last_vld <= 1'b0;
        end else if (clear) begin
            ent_vld  <= '0;
            fill_ptr <= '0;
            last_vld <= 1'b0;
        end else begin
            if (fill_wr) begin
                ent_vld[fill_ptr] <= 1'b1;
                fill_ptr          <= fill_ptr + 1'b1;
            end
            if (fill_vld) begin
                last_vld <= 1'b1;
            end
        end
    end

    // Oldest slot is overwritten once the store is full
    always_ff @(posedge clk) begin
        if (fill_wr) begin
            tag_mem[fill_ptr] <= fill_addr;
            dat_mem[fill_ptr] <= fill_data;
        end
        if (fill_vld) begin
            last_addr <= fill_addr;
            last_data <= fill_data;
        end
    end

endmodule

// ==== source/port_arbiter.sv ====
// One RAM read in flight at a time; an address offer keeps its winner until the RAM takes it
`timescale 1ns/1ps
`include "wcache_config.svh"

module port_arbiter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 work,
    input  logic                                 clear,
    input  logic [`WC_PORTS-1:0]                 miss_vld,
    input  wcache_pkg::wc_req_t [`WC_PORTS-1:0]  miss_req,
    input  logic [`WC_PORTS-1:0]                 slot_free,
    output logic                                 wram_add_vld,
    output logic                                 wram_add_last,
    output logic [`WC_ADDR_W-1:0]                wram_add_addr,
    input  logic                                 wram_add_rdy,
    input  logic                                 wram_dat_vld,
    output logic                                 wram_dat_rdy,
    input  logic [`WC_PORTS-1:0]                 rsp_rdy,
    output logic [$clog2(`WC_PORTS)-1:0]         grant_port,
    output logic                                 busy,
    output logic [`WC_ADDR_W-1:0]                fill_addr,
    output logic [`WC_PORTS-1:0]                 accept
);
    import wcache_pkg::*;

    localparam int PW = $clog2(`WC_PORTS);

    logic [`WC_PORTS-1:0] cand;
    logic [PW-1:0]        rr_ptr;
    logic [PW-1:0]        win;
    logic                 win_vld;
    wc_req_t              win_req;
    logic                 add_fire;
    logic                 dat_fire;

    // Only ports whose reply output can take the data compete
    assign cand = miss_vld & slot_free & {`WC_PORTS{work & ~busy}};

    // First candidate at or after the pointer
    always_comb begin
        int unsigned idx;
        win     = '0;
        win_vld = 1'b0;
        for (int k = 0; k < `WC_PORTS; k++) begin
            idx = (rr_ptr + k) % `WC_PORTS;
            if (!win_vld && cand[idx]) begin
                win_vld = 1'b1;
                win     = PW'(idx);
            end
        end
    end

    assign win_req       = miss_req[win];
    assign wram_add_vld  = win_vld;
    assign wram_add_addr = win_req.addr;
    assign wram_add_last = win_req.last;

    assign add_fire     = wram_add_vld & wram_add_rdy;
    // RAM is stalled by the owning row's back-pressure
    assign wram_dat_rdy = busy & rsp_rdy[grant_port];
    assign dat_fire     = wram_dat_vld & wram_dat_rdy;

    always_comb begin
        accept = '0;
        if (add_fire) begin
            accept[win] = 1'b1;
        end
    end

    // ====================
    // Outstanding read
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            rr_ptr     <= '0;
            grant_port <= '0;
        end else if (clear) begin
            busy   <= 1'b0;
            rr_ptr <= '0;
        end else if (add_fire) begin
            busy       <= 1'b1;
            grant_port <= win;
            rr_ptr     <= (win == PW'(`WC_PORTS - 1)) ? '0 : win + 1'b1;
        end else if (wram_add_vld) begin
            // Offer not taken, the same row stays first
            rr_ptr <= win;
        end else if (dat_fire) begin
            busy <= 1'b0;
        end
    end

    // Address of the read in flight, used to tag the fill
    always_ff @(posedge clk) begin
        if (add_fire) begin
            fill_addr <= win_req.addr;
        end
    end

endmodule

// ==== source/port_reply.sv ====
// Held hit beat takes precedence; RAM data passes through unregistered when this row owns the read
`timescale 1ns/1ps

module port_reply #(
    parameter type beat_t = wcache_pkg::wc_beat_t
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  hit_take,
    input  beat_t hit_beat,
    input  logic  ram_sel,
    input  beat_t ram_beat,
    input  logic  ram_vld,
    output logic  rsp_vld,
    output beat_t rsp_beat,
    input  logic  rsp_rdy,
    output logic  slot_free
);

    logic  hold_vld;
    beat_t hold_beat;

    // ====================
    // Hit beat register
    // ====================

    // A new hit may load in the same cycle the old beat leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_vld <= 1'b0;
        end else if (clear) begin
            hold_vld <= 1'b0;
        end else if (hit_take) begin
            hold_vld <= 1'b1;
        end else if (rsp_rdy) begin
            hold_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_take) begin
            hold_beat <= hit_beat;
        end
    end

    // ====================
    // Output select
    // ====================

    assign rsp_vld  = hold_vld | (ram_sel & ram_vld);
    assign rsp_beat = hold_vld ? hold_beat : ram_beat;

    // Empty, or the held beat leaves this cycle
    assign slot_free = ~hold_vld | rsp_rdy;

endmodule

// ==== source/wcache_config.svh ====
// Sizes are fixed at compile time; WC_IDX_W has to stay equal to log2 of WC_DEPTH
`ifndef WCACHE_CONFIG_SVH
`define WCACHE_CONFIG_SVH

// ====================
// Array geometry
// ====================

// Processing-element rows sharing the one RAM read port
`define WC_PORTS  4

// Weight RAM address and data widths
`define WC_ADDR_W 13
`define WC_DATA_W 8

// Associative store entries, filled round-robin
`define WC_DEPTH  8
`define WC_IDX_W  3

`endif

// ==== source/wcache_ctrl.sv ====
// Mode is taken from cfg_bypass with the configuration transfer; cfg_vld in work drops to idle
`timescale 1ns/1ps

module wcache_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cfg_vld,
    input  logic                 cfg_bypass,
    output logic                 cfg_rdy,
    output logic                 work,
    output logic                 clear,
    output wcache_pkg::wc_mode_t mode
);
    import wcache_pkg::*;

    wc_state_t state;
    wc_state_t state_nxt;

    // Idle -> cfg on transfer, one cycle in cfg, work until the next cfg_vld
    always_comb begin
        state_nxt = state;
        case (state)
            WC_IDLE: begin
                if (cfg_vld) begin
                    state_nxt = WC_CFG;
                end
            end
            WC_CFG:  state_nxt = WC_WORK;
            WC_WORK: begin
                if (cfg_vld) begin
                    state_nxt = WC_IDLE;
                end
            end
            default: state_nxt = WC_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= WC_IDLE;
            mode  <= WC_BYPASS;
        end else begin
            state <= state_nxt;
            if (cfg_vld && cfg_rdy) begin
                mode <= cfg_bypass ? WC_BYPASS : WC_LOOP;
            end
        end
    end

    assign cfg_rdy = (state == WC_IDLE);
    assign work    = (state == WC_WORK);
    // Empties store and reply stages as the FSM falls back to idle
    assign clear   = (state == WC_WORK) && cfg_vld;

endmodule

// ==== source/wcache_pkg.sv ====
// Payload layouts follow the config macros, with the data or address above the last flag
`include "wcache_config.svh"

package wcache_pkg;

    // ====================
    // Control encodings
    // ====================

    typedef enum logic [1:0] {
        WC_IDLE = 2'd0,
        WC_CFG  = 2'd1,
        WC_WORK = 2'd2
    } wc_state_t;

    // Bypass sends every request to RAM, loop caches returns
    typedef enum logic {
        WC_BYPASS = 1'b0,
        WC_LOOP   = 1'b1
    } wc_mode_t;

    // ====================
    // Payloads
    // ====================

    typedef struct packed {
        logic [`WC_ADDR_W-1:0] addr;
        logic                  last;
    } wc_req_t;

    typedef struct packed {
        logic [`WC_DATA_W-1:0] data;
        logic                  last;
    } wc_beat_t;

endpackage

// ==== source/weight_cache_top.sv ====
// Requests on a row wait while that row owns the RAM read; replies per row stay in request order
`timescale 1ns/1ps
`include "wcache_config.svh"

module weight_cache_top #(
    parameter type req_t  = wcache_pkg::wc_req_t,
    parameter type beat_t = wcache_pkg::wc_beat_t,
    parameter type mode_t = wcache_pkg::wc_mode_t
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cfg_vld,
    input  logic                                 cfg_bypass,
    output logic                                 cfg_rdy,
    input  logic [`WC_PORTS-1:0]                 req_vld,
    input  logic [`WC_PORTS-1:0]                 req_last,
    input  logic [`WC_PORTS-1:0][`WC_ADDR_W-1:0] req_addr,
    output logic [`WC_PORTS-1:0]                 req_rdy,
    output logic [`WC_PORTS-1:0]                 rsp_vld,
    output logic [`WC_PORTS-1:0]                 rsp_last,
    output logic [`WC_PORTS-1:0][`WC_DATA_W-1:0] rsp_data,
    input  logic [`WC_PORTS-1:0]                 rsp_rdy,
    output logic                                 wram_add_vld,
    output logic                                 wram_add_last,
    output logic [`WC_ADDR_W-1:0]                wram_add_addr,
    input  logic                                 wram_add_rdy,
    input  logic                                 wram_dat_vld,
    input  logic                                 wram_dat_last,
    input  logic [`WC_DATA_W-1:0]                wram_dat_data,
    output logic                                 wram_dat_rdy
);
    localparam int PW = $clog2(`WC_PORTS);

    logic                                 work;
    logic                                 clear;
    mode_t                                mode;
    logic [`WC_PORTS-1:0]                 hit;
    logic [`WC_PORTS-1:0][`WC_DATA_W-1:0] hit_data;
    logic [`WC_PORTS-1:0]                 miss_vld;
    req_t [`WC_PORTS-1:0]                 miss_req;
    logic [`WC_PORTS-1:0]                 slot_free;
    logic [`WC_PORTS-1:0]                 accept;
    logic [`WC_PORTS-1:0]                 blocked;
    logic [PW-1:0]                        grant_port;
    logic                                 busy;
    logic [`WC_ADDR_W-1:0]                fill_addr;
    logic                                 dat_fire;
    beat_t                                ram_beat;

    assign dat_fire = wram_dat_vld & wram_dat_rdy;
    assign ram_beat = {wram_dat_data, wram_dat_last};

    wcache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_vld    (cfg_vld),
        .cfg_bypass (cfg_bypass),
        .cfg_rdy    (cfg_rdy),
        .work       (work),
        .clear      (clear),
        .mode       (mode)
    );

    hit_store u_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .work      (work),
        .clear     (clear),
        .mode      (mode),
        .look_addr (req_addr),
        .hit       (hit),
        .hit_data  (hit_data),
        .fill_vld  (dat_fire),
        .fill_addr (fill_addr),
        .fill_data (wram_dat_data)
    );

    port_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .work          (work),
        .clear         (clear),
        .miss_vld      (miss_vld),
        .miss_req      (miss_req),
        .slot_free     (slot_free),
        .wram_add_vld  (wram_add_vld),
        .wram_add_last (wram_add_last),
        .wram_add_addr (wram_add_addr),
        .wram_add_rdy  (wram_add_rdy),
        .wram_dat_vld  (wram_dat_vld),
        .wram_dat_rdy  (wram_dat_rdy),
        .rsp_rdy       (rsp_rdy),
        .grant_port    (grant_port),
        .busy          (busy),
        .fill_addr     (fill_addr),
        .accept        (accept)
    );

    // ====================
    // Per-row glue
    // ====================

    for (genvar p = 0; p < `WC_PORTS; p++) begin : gen_port
        logic  ram_sel;
        logic  hit_ok;
        beat_t rsp_beat;

        assign ram_sel    = busy && (grant_port == PW'(p));
        // Row released in the cycle its RAM data is taken
        assign blocked[p] = ram_sel & ~dat_fire;
        assign hit_ok     = hit[p] & slot_free[p] & ~blocked[p];

        assign miss_vld[p] = req_vld[p] & work & ~hit[p] & ~blocked[p];
        assign miss_req[p] = {req_addr[p], req_last[p]};
        assign req_rdy[p]  = hit_ok | accept[p];

        port_reply #(
            .beat_t (beat_t)
        ) u_reply (
            .clk       (clk),
            .rst_n     (rst_n),
            .clear     (clear),
            .hit_take  (req_vld[p] & hit_ok),
            .hit_beat  ({hit_data[p], req_last[p]}),
            .ram_sel   (ram_sel),
            .ram_beat  (ram_beat),
            .ram_vld   (wram_dat_vld),
            .rsp_vld   (rsp_vld[p]),
            .rsp_beat  (rsp_beat),
            .rsp_rdy   (rsp_rdy[p]),
            .slot_free (slot_free[p])
        );

        assign {rsp_data[p], rsp_last[p]} = rsp_beat;
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/wcache_pkg.sv
source/wcache_ctrl.sv
source/port_arbiter.sv
source/hit_store.sv
source/port_reply.sv
source/weight_cache_top.sv
bench/wcache_assert.sv
bench/tb_weight_cache.sv
